// ==== build.f ====
src/audio_mix_pkg.sv
src/audio_ctrl_regs.sv
src/audio_sum_stage.sv
src/audio_compress_stage.sv
src/audio_mixer_top.sv
testbench/audio_mixer_sva.sv
testbench/audio_mixer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the audio mixer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module audio_mixer_tb -f build.f -o sim_audio_mixer

./obj_dir/sim_audio_mixer | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== src/audio_compress_stage.sv ====
// Compression stage: soft-knee 2x or 4x boost per channel, or bypass when boost is off
`timescale 1ns/1ns

module audio_compress_stage (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               sum_valid,
	input  logic [audio_mix_pkg::sample_w-1:0] sum_left,
	input  logic [audio_mix_pkg::sample_w-1:0] sum_right,
	input  audio_mix_pkg::boost_t              boost,
	output logic                               audio_valid,
	output logic [audio_mix_pkg::sample_w-1:0] audio_left,
	output logic [audio_mix_pkg::sample_w-1:0] audio_right
);

	logic [audio_mix_pkg::sample_w-1:0] next_left;
	logic [audio_mix_pkg::sample_w-1:0] next_right;

	// Linear below the knee, compressed slope above it
	function automatic logic [15:0] curve(
		input logic [15:0] mag,
		input int          x,
		input int          a,
		input int          f,
		input int          b
	);
		if (mag < 16'(x))
			return 16'(mag * a);
		return 16'(((mag - 16'(x)) / f) + b);
	endfunction

	// Whole channel, magnitude in and sign back out
	function automatic logic [15:0] compress(
		input logic [15:0]           inp,
		input audio_mix_pkg::boost_t mode
	);
		logic [15:0] mag;
		logic [15:0] v;
		mag = inp[15] ? (~inp + 16'd1) : inp;
		case (mode)
			audio_mix_pkg::boost_2x:
				v = curve(mag, audio_mix_pkg::comp_x_2x, audio_mix_pkg::comp_a_2x,
					audio_mix_pkg::comp_f_2x, audio_mix_pkg::comp_b_2x);
			// Reserved code acts as 4x
			default:
				v = curve(mag, audio_mix_pkg::comp_x_4x, audio_mix_pkg::comp_a_4x,
					audio_mix_pkg::comp_f_4x, audio_mix_pkg::comp_b_4x);
		endcase
		return inp[15] ? (~v + 16'd1) : v;
	endfunction

	////////////////////
	// Bypass select
	////////////////////

	always_comb begin
		if (boost == audio_mix_pkg::boost_off) begin
			next_left  = sum_left;
			next_right = sum_right;
		end else begin
			next_left  = compress(sum_left, boost);
			next_right = compress(sum_right, boost);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			audio_valid <= 1'b0;
		else
			audio_valid <= sum_valid;
	end

	always_ff @(posedge clk_sys) begin
		audio_left  <= next_left;
		audio_right <= next_right;
	end

endmodule

// ==== src/audio_ctrl_regs.sv ====
// Mixer control register behind an AXI4-Lite slave, decoded into volume, boost and mute
`timescale 1ns/1ns

module audio_ctrl_regs #(
	parameter int addr_w = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	// Write address and data
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [addr_w-1:0]     awaddr,
	input  logic                  wvalid,
	output logic                  wready,
	input  logic [31:0]           wdata,
	input  logic [3:0]            wstrb,

	// Write response
	output logic                  bvalid,
	input  logic                  bready,
	output logic [1:0]            bresp,

	// Read
	input  logic                  arvalid,
	output logic                  arready,
	input  logic [addr_w-1:0]     araddr,
	output logic                  rvalid,
	input  logic                  rready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,

	// Decoded fields
	output logic [1:0]            spk_vol,
	output audio_mix_pkg::boost_t boost,
	output logic                  mt32_mute
);

	audio_mix_pkg::axi_fsm_t state;

	logic wr_fire;
	logic rd_fire;
	logic wr_hit;
	logic rd_hit;
	logic [31:0] ctrl_word;

	// Write has priority over a read offered in the same cycle
	assign awready = (state == audio_mix_pkg::st_idle) && awvalid && wvalid;
	assign wready  = awready;
	assign arready = (state == audio_mix_pkg::st_idle) && arvalid && !(awvalid || wvalid);

	assign wr_fire = awready;
	assign rd_fire = arready;

	assign wr_hit = (awaddr == addr_w'(audio_mix_pkg::ctrl_addr));
	assign rd_hit = (araddr == addr_w'(audio_mix_pkg::ctrl_addr));

	assign bvalid = (state == audio_mix_pkg::st_write_resp);
	assign rvalid = (state == audio_mix_pkg::st_read_resp);

	// Unused bits read as zero
	always_comb begin
		ctrl_word = '0;
		ctrl_word[audio_mix_pkg::ctrl_spk_vol_lsb +: 2] = spk_vol;
		ctrl_word[audio_mix_pkg::ctrl_boost_lsb +: 2]   = boost;
		ctrl_word[audio_mix_pkg::ctrl_mute_bit]         = mt32_mute;
	end

	////////////////////
	// FSM and fields
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= audio_mix_pkg::st_idle;
			spk_vol   <= '0;
			boost     <= audio_mix_pkg::boost_off;
			mt32_mute <= 1'b0;
		end else begin
			case (state)
				audio_mix_pkg::st_idle: begin
					if (wr_fire) begin
						state <= audio_mix_pkg::st_write_resp;
						// All fields live in byte 0
						if (wr_hit && wstrb[0]) begin
							spk_vol   <= wdata[audio_mix_pkg::ctrl_spk_vol_lsb +: 2];
							boost     <= audio_mix_pkg::boost_t'(
								wdata[audio_mix_pkg::ctrl_boost_lsb +: 2]);
							mt32_mute <= wdata[audio_mix_pkg::ctrl_mute_bit];
						end
					end else if (rd_fire) begin
						state <= audio_mix_pkg::st_read_resp;
					end
				end
				audio_mix_pkg::st_write_resp: begin
					if (bready)
						state <= audio_mix_pkg::st_idle;
				end
				audio_mix_pkg::st_read_resp: begin
					if (rready)
						state <= audio_mix_pkg::st_idle;
				end
				default: state <= audio_mix_pkg::st_idle;
			endcase
		end
	end

	// Response payload, captured at the handshake
	always_ff @(posedge clk_sys) begin
		if (wr_fire)
			bresp <= wr_hit ? audio_mix_pkg::resp_okay : audio_mix_pkg::resp_slverr;
		if (rd_fire) begin
			rresp <= rd_hit ? audio_mix_pkg::resp_okay : audio_mix_pkg::resp_slverr;
			rdata <= rd_hit ? ctrl_word : 32'd0;
		end
	end

endmodule

// ==== src/audio_mix_pkg.sv ====
// Audio mixer shared definitions: widths, control register map, boost modes, compressor curves
package audio_mix_pkg;

	// Sample and sum widths
	localparam int sample_w = 16;
	localparam int sum_w    = 17;

	// Boost mode, value 3 is reserved and behaves as 4x
	typedef enum logic [1:0] {
		boost_off    = 2'd0,
		boost_2x     = 2'd1,
		boost_4x     = 2'd2,
		boost_4x_alt = 2'd3
	} boost_t;

	////////////////////
	// Control register map
	////////////////////

	localparam int ctrl_addr        = 0;
	localparam int ctrl_spk_vol_lsb = 0;
	localparam int ctrl_boost_lsb   = 2;
	localparam int ctrl_mute_bit    = 4;

	// Speaker bit lands at bit 11 before the volume shift
	localparam int spk_base_shift = 11;

	////////////////////
	// Compressor curves
	////////////////////

	// 2x curve: knee, gain below knee, divisor and offset above it
	localparam int comp_x_2x = 14044;
	localparam int comp_a_2x = 2;
	localparam int comp_f_2x = 4;
	localparam int comp_b_2x = 28088;

	// 4x curve
	localparam int comp_x_4x = 7400;
	localparam int comp_a_4x = 4;
	localparam int comp_f_4x = 8;
	localparam int comp_b_4x = 29600;

	// AXI response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Register block states
	typedef enum logic [1:0] {
		st_idle       = 2'd0,
		st_write_resp = 2'd1,
		st_read_resp  = 2'd2
	} axi_fsm_t;

endpackage

// ==== src/audio_mixer_top.sv ====
// Audio mixer top: AXI4-Lite control register, sum-and-clamp stage and compressor
`timescale 1ns/1ns

module audio_mixer_top #(
	parameter int addr_w = 4
) (
	input  logic                               clk_sys,
	input  logic                               reset,

	// AXI4-Lite control port
	input  logic                               awvalid,
	output logic                               awready,
	input  logic [addr_w-1:0]                  awaddr,
	input  logic                               wvalid,
	output logic                               wready,
	input  logic [31:0]                        wdata,
	input  logic [3:0]                         wstrb,
	output logic                               bvalid,
	input  logic                               bready,
	output logic [1:0]                         bresp,
	input  logic                               arvalid,
	output logic                               arready,
	input  logic [addr_w-1:0]                  araddr,
	output logic                               rvalid,
	input  logic                               rready,
	output logic [31:0]                        rdata,
	output logic [1:0]                         rresp,

	// Sample inputs
	input  logic                               sample_valid,
	input  logic [audio_mix_pkg::sample_w-1:0] sb_left,
	input  logic [audio_mix_pkg::sample_w-1:0] sb_right,
	input  logic [audio_mix_pkg::sample_w-1:0] mt32_left,
	input  logic [audio_mix_pkg::sample_w-1:0] mt32_right,
	input  logic                               speaker,

	// Mixed output
	output logic                               audio_valid,
	output logic [audio_mix_pkg::sample_w-1:0] audio_left,
	output logic [audio_mix_pkg::sample_w-1:0] audio_right
);

	logic [1:0]                         spk_vol;
	audio_mix_pkg::boost_t              boost;
	logic                               mt32_mute;
	logic                               sum_valid;
	logic [audio_mix_pkg::sample_w-1:0] sum_left;
	logic [audio_mix_pkg::sample_w-1:0] sum_right;

	////////////////////
	// Control
	////////////////////

	audio_ctrl_regs #(
		.addr_w(addr_w)
	) u_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.awvalid   (awvalid),
		.awready   (awready),
		.awaddr    (awaddr),
		.wvalid    (wvalid),
		.wready    (wready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.arvalid   (arvalid),
		.arready   (arready),
		.araddr    (araddr),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata),
		.rresp     (rresp),
		.spk_vol   (spk_vol),
		.boost     (boost),
		.mt32_mute (mt32_mute)
	);

	////////////////////
	// Audio pipeline
	////////////////////

	audio_sum_stage u_sum (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sb_left      (sb_left),
		.sb_right     (sb_right),
		.mt32_left    (mt32_left),
		.mt32_right   (mt32_right),
		.speaker      (speaker),
		.spk_vol      (spk_vol),
		.mt32_mute    (mt32_mute),
		.sum_valid    (sum_valid),
		.sum_left     (sum_left),
		.sum_right    (sum_right)
	);

	audio_compress_stage u_comp (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sum_valid   (sum_valid),
		.sum_left    (sum_left),
		.sum_right   (sum_right),
		.boost       (boost),
		.audio_valid (audio_valid),
		.audio_left  (audio_left),
		.audio_right (audio_right)
	);

endmodule

// ==== src/audio_sum_stage.sv ====
// Sum stage: scales the speaker bit, adds the three sources and saturates to 16 bits
`timescale 1ns/1ns

module audio_sum_stage (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               sample_valid,
	input  logic [audio_mix_pkg::sample_w-1:0] sb_left,
	input  logic [audio_mix_pkg::sample_w-1:0] sb_right,
	input  logic [audio_mix_pkg::sample_w-1:0] mt32_left,
	input  logic [audio_mix_pkg::sample_w-1:0] mt32_right,
	input  logic                               speaker,
	input  logic [1:0]                         spk_vol,
	input  logic                               mt32_mute,
	output logic                               sum_valid,
	output logic [audio_mix_pkg::sample_w-1:0] sum_left,
	output logic [audio_mix_pkg::sample_w-1:0] sum_right
);

	logic [audio_mix_pkg::sum_w-1:0] spk_term;
	logic [audio_mix_pkg::sum_w-1:0] raw_left;
	logic [audio_mix_pkg::sum_w-1:0] raw_right;
	logic                            raw_valid;

	// One channel: sign-extended SB plus speaker plus optional MT-32
	function automatic logic [audio_mix_pkg::sum_w-1:0] mix(
		input logic [audio_mix_pkg::sample_w-1:0] sb,
		input logic [audio_mix_pkg::sample_w-1:0] mt,
		input logic [audio_mix_pkg::sum_w-1:0]    spk,
		input logic                               mute
	);
		logic [audio_mix_pkg::sum_w-1:0] mt_ext;
		mt_ext = mute ? '0 : {mt[audio_mix_pkg::sample_w-1], mt};
		return {sb[audio_mix_pkg::sample_w-1], sb} + spk + mt_ext;
	endfunction

	// Clamp when the two top bits disagree
	function automatic logic [audio_mix_pkg::sample_w-1:0] clamp(
		input logic [audio_mix_pkg::sum_w-1:0] raw
	);
		if (raw[audio_mix_pkg::sum_w-1] ^ raw[audio_mix_pkg::sum_w-2])
			return {raw[audio_mix_pkg::sum_w-1], {(audio_mix_pkg::sample_w-1){raw[audio_mix_pkg::sum_w-2]}}};
		return raw[audio_mix_pkg::sample_w-1:0];
	endfunction

	// Speaker sits at bit 11, volume moves it up to bit 14
	assign spk_term = {{(audio_mix_pkg::sum_w-1){1'b0}}, speaker}
		<< (audio_mix_pkg::spk_base_shift + spk_vol);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			raw_valid <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			raw_valid <= sample_valid;
			sum_valid <= raw_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		raw_left  <= mix(sb_left, mt32_left, spk_term, mt32_mute);
		raw_right <= mix(sb_right, mt32_right, spk_term, mt32_mute);
		sum_left  <= clamp(raw_left);
		sum_right <= clamp(raw_right);
	end

endmodule

// ==== testbench/audio_mixer_sva.sv ====
// Audio mixer assertions: AXI response hold, pipeline latency and ready state in reset
`timescale 1ns/1ns

module audio_mixer_sva (
	input logic clk_sys,
	input logic reset,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic sample_valid,
	input logic audio_valid
);

	// Write and read responses stay up until the master takes them
	bvalid_hold: assert property (@(posedge clk_sys) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge clk_sys) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	////////////////////
	// Audio path
	////////////////////

	// Three register stages, no stalls
	audio_latency: assert property (@(posedge clk_sys) disable iff (reset)
		audio_valid == $past(sample_valid, 3))
		else $error("audio_valid does not follow sample_valid by 3 cycles");

	// Register block comes out of reset idle, no response and no write ready
	ready_in_reset: assert property (@(posedge clk_sys)
		reset |=> !bvalid && !rvalid && !awready && !wready)
		else $error("AXI ready or response high after reset");

endmodule

// ==== testbench/audio_mixer_tb.sv ====
// Audio mixer testbench: AXI register access and random samples against a reference model
`timescale 1ns/1ns

module audio_mixer_tb;

	localparam int addr_w       = 4;
	localparam int reset_cycles = 5;
	localparam int n_reg_rand   = 8;
	localparam int n_mix        = 64;
	localparam int n_full       = 32;
	localparam int n_mute       = 32;
	localparam int n_curve      = 24;
	// Register test, then one write and read back per control setting
	localparam int n_xfers   = 2 * n_reg_rand + 5 + 2 * (2 + 12);
	localparam int n_samples = n_mix + n_full + n_mute + 12 * n_curve;
	localparam int limit_cycles = (n_xfers + n_samples) * 20 + reset_cycles;

	logic clk_sys;
	logic reset;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [addr_w-1:0] awaddr, araddr;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	logic sample_valid, speaker, audio_valid;
	logic [15:0] sb_left, sb_right, mt32_left, mt32_right;
	logic [15:0] audio_left, audio_right;

	logic [31:0] lcg_state;
	logic [31:0] exp_q[$];
	int due_q[$];
	int cycle = 0;
	int cur_vol;
	int cur_boost;
	logic cur_mute;

	audio_mixer_top #(
		.addr_w(addr_w)
	) dut (
		.clk_sys(clk_sys), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.sample_valid(sample_valid), .sb_left(sb_left), .sb_right(sb_right),
		.mt32_left(mt32_left), .mt32_right(mt32_right), .speaker(speaker),
		.audio_valid(audio_valid), .audio_left(audio_left), .audio_right(audio_right)
	);

	bind audio_mixer_top audio_mixer_sva sva (
		.clk_sys(clk_sys), .reset(reset), .awready(awready), .wready(wready),
		.bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
		.sample_valid(sample_valid), .audio_valid(audio_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cycle <= cycle + 1;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "Run aborted");
	endtask

	////////////////////
	// Reference model
	////////////////////

	// 17-bit sum, clamped when the two top bits disagree
	function automatic logic [15:0] saturate_sum(input logic [15:0] sb, input logic [15:0] mt,
		input logic spk, input int vol, input logic mute);
		int total;
		logic [31:0] bits;
		total = int'($signed(sb)) + (int'(spk) << (audio_mix_pkg::spk_base_shift + vol));
		if (!mute)
			total = total + int'($signed(mt));
		bits = total;
		if (bits[16] != bits[15])
			return bits[16] ? 16'h8000 : 16'h7FFF;
		return bits[15:0];
	endfunction

	function automatic logic [15:0] apply_boost(input logic [15:0] v, input int mode);
		int mag, x, a, f, b, r;
		if (mode == 0)
			return v;
		if (mode == 1) begin
			x = audio_mix_pkg::comp_x_2x;
			a = audio_mix_pkg::comp_a_2x;
			f = audio_mix_pkg::comp_f_2x;
			b = audio_mix_pkg::comp_b_2x;
		end else begin
			x = audio_mix_pkg::comp_x_4x;
			a = audio_mix_pkg::comp_a_4x;
			f = audio_mix_pkg::comp_f_4x;
			b = audio_mix_pkg::comp_b_4x;
		end
		mag = v[15] ? 65536 - int'(v) : int'(v);
		r = (mag < x) ? mag * a : (mag - x) / f + b;
		if (v[15])
			r = -r;
		return 16'(r);
	endfunction

	// Output checker, sampled mid-cycle
	always @(negedge clk_sys) begin : monitor
		logic [31:0] expected;
		int due;
		if (!reset && audio_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("audio_valid seen with no sample in flight");
			end else begin
				expected = exp_q.pop_front();
				due = due_q.pop_front();
				check_value("audio_left", {16'h0, audio_left}, {16'h0, expected[31:16]});
				check_value("audio_right", {16'h0, audio_right}, {16'h0, expected[15:0]});
				check_value("audio_valid cycle", cycle, due);
			end
		end
	end

	////////////////////
	// AXI tasks
	////////////////////

	task automatic axi_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int hold;
		@(posedge clk_sys);
		#1;
		awvalid = 1'b1;
		awaddr = addr;
		wvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		@(negedge clk_sys);
		while (!awready)
			@(negedge clk_sys);
		check_value("wready", wready, 1);
		@(posedge clk_sys);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		check_value("bvalid", bvalid, 1);
		resp = bresp;
		// Response may wait up to two cycles before it is taken
		hold = int'(lcg_next() % 3);
		for (int i = 0; i < hold; i++) begin
			@(posedge clk_sys);
			#1;
		end
		bready = 1'b1;
		@(posedge clk_sys);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [addr_w-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int hold;
		@(posedge clk_sys);
		#1;
		arvalid = 1'b1;
		araddr = addr;
		@(negedge clk_sys);
		while (!arready)
			@(negedge clk_sys);
		@(posedge clk_sys);
		#1;
		arvalid = 1'b0;
		check_value("rvalid", rvalid, 1);
		data = rdata;
		resp = rresp;
		hold = int'(lcg_next() % 3);
		for (int i = 0; i < hold; i++) begin
			@(posedge clk_sys);
			#1;
		end
		rready = 1'b1;
		@(posedge clk_sys);
		#1;
		rready = 1'b0;
	endtask

	// Write with junk in the unused bits, then read it back
	task automatic set_control(input int vol, input int mode, input logic mute);
		logic [31:0] field;
		logic [31:0] data;
		logic [1:0] resp;
		field = {27'd0, mute, 2'(mode), 2'(vol)};
		axi_write(0, (lcg_next() & 32'hFFFF_FFE0) | field, 4'hF, resp);
		check_value("bresp", resp, audio_mix_pkg::resp_okay);
		axi_read(0, data, resp);
		check_value("rdata", data, field);
		check_value("rresp", resp, audio_mix_pkg::resp_okay);
		cur_vol = vol;
		cur_boost = mode;
		cur_mute = mute;
	endtask

	////////////////////
	// Sample stimulus
	////////////////////

	task automatic send_sample(input logic [15:0] sl, input logic [15:0] sr,
		input logic [15:0] ml, input logic [15:0] mr, input logic spk);
		logic [15:0] el, er;
		@(posedge clk_sys);
		#1;
		sample_valid = 1'b1;
		sb_left = sl;
		sb_right = sr;
		mt32_left = ml;
		mt32_right = mr;
		speaker = spk;
		el = apply_boost(saturate_sum(sl, ml, spk, cur_vol, cur_mute), cur_boost);
		er = apply_boost(saturate_sum(sr, mr, spk, cur_vol, cur_mute), cur_boost);
		exp_q.push_back({el, er});
		due_q.push_back(cycle + 3);
	endtask

	// Magnitude within 32 of either knee, either sign
	function automatic logic [15:0] knee_value(input logic [31:0] r);
		int mag;
		mag = (r[31] ? audio_mix_pkg::comp_x_2x : audio_mix_pkg::comp_x_4x)
			+ int'(r[29:24]) - 32;
		return r[30] ? 16'(-mag) : 16'(mag);
	endfunction

	// Kind 0 is fully random, 1 is near full scale, 2 is near a knee
	task automatic send_random(input int kind);
		logic [31:0] r1, r2, r3, r4;
		logic [15:0] sl, sr, ml, mr;
		r1 = lcg_next();
		r2 = lcg_next();
		r3 = lcg_next();
		r4 = lcg_next();
		if (kind == 1) begin
			sl = r1[31] ? (16'h8000 | 16'(r1[28:16])) : (16'h6000 | 16'(r1[28:16]));
			sr = r2[31] ? (16'h8000 | 16'(r2[28:16])) : (16'h6000 | 16'(r2[28:16]));
			ml = r1[31] ? (16'hC000 | 16'(r3[28:16])) : (16'h2000 | 16'(r3[28:16]));
			mr = r2[31] ? (16'hC000 | 16'(r4[28:16])) : (16'h2000 | 16'(r4[28:16]));
			send_sample(sl, sr, ml, mr, r3[15]);
		end else if (kind == 2) begin
			send_sample(knee_value(r1), knee_value(r2), 16'h0, 16'h0, 1'b0);
		end else begin
			send_sample(r1[31:16], r2[31:16], r3[31:16], r4[31:16], r1[15]);
		end
	endtask

	task automatic drain_pipeline();
		@(posedge clk_sys);
		#1;
		sample_valid = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk_sys);
		repeat (2) @(posedge clk_sys);
	endtask

	initial begin
		repeat (limit_cycles) @(posedge clk_sys);
		abort_run("Watchdog expired before the tests finished");
	end

	initial begin : main
		logic [31:0] v, data;
		logic [1:0] resp;
		lcg_state = 32'd7184;
		reset = 1'b1;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		{sample_valid, speaker} = '0;
		{sb_left, sb_right, mt32_left, mt32_right} = '0;
		repeat (reset_cycles) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Register access, unused bits read back as zero
		for (int i = 0; i < n_reg_rand; i++) begin
			v = lcg_next();
			axi_write(0, v, 4'hF, resp);
			check_value("bresp", resp, audio_mix_pkg::resp_okay);
			axi_read(0, data, resp);
			check_value("rdata", data, v & 32'h1F);
			check_value("rresp", resp, audio_mix_pkg::resp_okay);
		end
		axi_write(4, ~v, 4'hF, resp);
		check_value("bresp", resp, audio_mix_pkg::resp_slverr);
		axi_read(0, data, resp);
		check_value("rdata", data, v & 32'h1F);
		axi_read(4, data, resp);
		check_value("rdata", data, 0);
		check_value("rresp", resp, audio_mix_pkg::resp_slverr);
		// Byte 0 strobe off leaves the fields alone
		axi_write(0, ~v, 4'b1110, resp);
		check_value("bresp", resp, audio_mix_pkg::resp_okay);
		axi_read(0, data, resp);
		check_value("rdata", data, v & 32'h1F);

		// Plain mix, then overflow near full scale
		set_control(0, 0, 1'b0);
		for (int i = 0; i < n_mix; i++)
			send_random(0);
		for (int i = 0; i < n_full; i++)
			send_random(1);
		drain_pipeline();

		set_control(2, 0, 1'b1);
		for (int i = 0; i < n_mute; i++)
			send_random(int'(lcg_next() >> 31));
		drain_pipeline();

		// Every volume against each boost curve
		for (int vol = 0; vol < 4; vol++) begin
			for (int mode = 1; mode < 4; mode++) begin
				set_control(vol, mode, 1'b0);
				for (int i = 0; i < n_curve; i++)
					send_random(int'(lcg_next() % 3));
				drain_pipeline();
			end
		end

		$display("TB PASSED");
		$finish;
	end

endmodule
